// File: design/cpuSettings.svh
// Core sizing. Data and instructions share one word width
// Code occupies the lower CPU_CODE_WORDS words of the unified memory
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and instruction width
`define CPU_WORD_BITS 16

// Unified memory depth in words
`define CPU_MEM_WORDS 256

// Code region, PC wraps inside it
`define CPU_CODE_WORDS 128

// General registers, r0 reads as zero
`define CPU_REG_COUNT 8

`endif

// File: design/isaPkg.sv
// Instruction set types. Opcodes outside opcode_t are illegal and trap
`default_nettype none

package isaPkg;

	`include "cpuSettings.svh"

	typedef logic [`CPU_WORD_BITS-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIdx_t;

	// Instruction fields
	//   opcode [15:12], rd [11:9], rs [8:6], rt [5:3], signed imm6 [5:0]
	// Store writes rd to memory at rs+imm6
	// Beqz tests rs, target is pc+1+imm6
	typedef enum logic [3:0] {
		opAdd   = 4'h0,
		opSub   = 4'h1,
		opAnd   = 4'h2,
		opXor   = 4'h3,
		opAddi  = 4'h4,
		opLoad  = 4'h5,
		opStore = 4'h6,
		opBeqz  = 4'h7,
		opHalt  = 4'h8,
		opNop   = 4'h9
	} opcode_t;

endpackage

`default_nettype wire

// File: design/memPkg.sv
// Memory addressing and arbitration types
`default_nettype none

package memPkg;

	`include "cpuSettings.svh"

	typedef logic [$clog2(`CPU_MEM_WORDS)-1:0] memAddr_t;

	// Grant decision, one owner per cycle
	typedef enum logic [1:0] {
		ownNone,
		ownLoad,
		ownData,
		ownFetch
	} memOwner_t;

endpackage

`default_nettype wire

// File: design/cpuLinks.sv
// Links between the pipeline stages and the memory arbiter
// memBus reads are combinational, valid while grant is high
`timescale 1ns/100ps
`default_nettype none

interface memBus;
	import isaPkg::*;
	import memPkg::*;

	logic req;
	logic write;
	memAddr_t addr;
	word_t wdata;
	word_t rdata;
	logic grant;

	modport requester (output req, write, addr, wdata, input rdata, grant);
	modport arbiter (input req, write, addr, wdata, output rdata, grant);
endinterface

interface decExLink;
	import isaPkg::*;
	import memPkg::*;

	logic valid;
	opcode_t op;
	regIdx_t dest;
	logic writesReg;
	word_t aVal;
	word_t bVal;
	word_t imm;
	memAddr_t pc;

	modport producer (output valid, op, dest, writesReg, aVal, bVal, imm, pc);
	modport consumer (input valid, op, dest, writesReg, aVal, bVal, imm, pc);
endinterface

interface exMemLink;
	import isaPkg::*;

	logic valid;
	opcode_t op;
	regIdx_t dest;
	logic writesReg;
	word_t result;
	word_t storeData;

	modport producer (output valid, op, dest, writesReg, result, storeData);
	modport consumer (input valid, op, dest, writesReg, result, storeData);
	// Hazard view for decode
	modport monitor (input valid, dest, writesReg);
endinterface

`default_nettype wire

// File: design/sharedMemory.sv
// Unified memory. Load port wins during rst, then data, then fetch
// Array has no reset, so the whole code region should be loaded
`timescale 1ns/100ps
`default_nettype none

`include "cpuSettings.svh"

module sharedMemory (
	input logic clk,
	input logic rst,
	input logic loadEn,
	input memPkg::memAddr_t loadAddr,
	input isaPkg::word_t loadData,
	memBus.arbiter fetchBus,
	memBus.arbiter dataBus
);
	import isaPkg::*;
	import memPkg::*;

	word_t mem [`CPU_MEM_WORDS];
	memOwner_t owner;

	always_comb begin
		if (rst && loadEn) begin
			owner = ownLoad;
		end else if (dataBus.req) begin
			owner = ownData;
		end else if (fetchBus.req) begin
			owner = ownFetch;
		end else begin
			owner = ownNone;
		end
	end

	// Fetch only reads, so only load and data can write
	always_ff @(posedge clk) begin
		case (owner)
			ownLoad: begin
				mem[loadAddr] <= loadData;
			end
			ownData: begin
				if (dataBus.write) begin
					mem[dataBus.addr] <= dataBus.wdata;
				end
			end
			default: begin
			end
		endcase
	end

	// Both read ports always look and grant says whose data counts
	assign fetchBus.rdata = mem[fetchBus.addr];
	assign dataBus.rdata = mem[dataBus.addr];
	assign fetchBus.grant = (owner == ownFetch);
	assign dataBus.grant = (owner == ownData);

endmodule

`default_nettype wire

// File: design/fetchStage.sv
// PC and fetch register. A lost grant or halt yields a bubble, not a repeat
`timescale 1ns/100ps
`default_nettype none

`include "cpuSettings.svh"

module fetchStage (
	input logic clk,
	input logic rst,
	memBus.requester bus,
	input logic stall,
	input logic redirect,
	input memPkg::memAddr_t redirectPc,
	input logic halted,
	output isaPkg::word_t instr,
	output memPkg::memAddr_t instrPc,
	output logic instrValid
);
	import isaPkg::*;
	import memPkg::*;

	localparam int PC_BITS = $clog2(`CPU_CODE_WORDS);

	logic [PC_BITS-1:0] pc;

	// Code sits in the lower region
	assign bus.addr = memAddr_t'(pc);
	assign bus.req = !halted;
	assign bus.write = 1'b0;
	assign bus.wdata = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			instrValid <= 1'b0;
		end else if (redirect) begin
			// Drop the instruction in decode and the one fetched now
			pc <= redirectPc[PC_BITS-1:0];
			instrValid <= 1'b0;
		end else if (!stall) begin
			instrValid <= bus.grant;
			if (bus.grant) begin
				pc <= pc + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.grant && !stall) begin
			instr <= bus.rdata;
			instrPc <= bus.addr;
		end
	end

endmodule

`default_nettype wire

// File: design/decodeStage.sv
// Register file, decode and interlock. No forwarding, so any pending writer
// of a source in execute or memory stalls decode and a bubble is issued
`timescale 1ns/100ps
`default_nettype none

`include "cpuSettings.svh"

module decodeStage (
	input logic clk,
	input logic rst,
	input isaPkg::word_t instr,
	input memPkg::memAddr_t instrPc,
	input logic instrValid,
	input logic redirect,
	input logic wbEn,
	input isaPkg::regIdx_t wbReg,
	input isaPkg::word_t wbData,
	output logic stall,
	output logic err,
	decExLink.producer toEx,
	exMemLink.monitor exMon
);
	import isaPkg::*;

	word_t regs [`CPU_REG_COUNT];

	opcode_t op;
	regIdx_t rd;
	regIdx_t srcA;
	regIdx_t srcB;
	word_t immExt;
	word_t aVal;
	word_t bVal;
	logic usesA;
	logic usesB;
	logic writes;
	logic illegal;
	logic hazA;
	logic hazB;
	logic exBusy;
	logic memBusy;

	assign op = opcode_t'(instr[15:12]);
	assign rd = instr[11:9];
	assign srcA = instr[8:6];
	// Store reads its data from rd
	assign srcB = (op == opStore) ? instr[11:9] : instr[5:3];
	assign immExt = {{(`CPU_WORD_BITS-6){instr[5]}}, instr[5:0]};

	always_comb begin
		usesA = 1'b0;
		usesB = 1'b0;
		writes = 1'b0;
		illegal = 1'b0;
		case (op)
			opAdd, opSub, opAnd, opXor: begin
				usesA = 1'b1;
				usesB = 1'b1;
				writes = 1'b1;
			end
			opAddi, opLoad: begin
				usesA = 1'b1;
				writes = 1'b1;
			end
			opStore: begin
				usesA = 1'b1;
				usesB = 1'b1;
			end
			opBeqz: begin
				usesA = 1'b1;
			end
			opHalt, opNop: begin
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

	// Same-cycle writeback is visible to the read
	assign aVal = (srcA == '0) ? '0 : (wbEn && wbReg == srcA) ? wbData : regs[srcA];
	assign bVal = (srcB == '0) ? '0 : (wbEn && wbReg == srcB) ? wbData : regs[srcB];

	assign exBusy = toEx.valid && toEx.writesReg;
	assign memBusy = exMon.valid && exMon.writesReg;
	assign hazA = (srcA != '0) && ((exBusy && toEx.dest == srcA) ||
		(memBusy && exMon.dest == srcA));
	assign hazB = (srcB != '0) && ((exBusy && toEx.dest == srcB) ||
		(memBusy && exMon.dest == srcB));
	assign stall = instrValid && ((usesA && hazA) || (usesB && hazB));

	always_ff @(posedge clk) begin
		if (wbEn && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			toEx.valid <= 1'b0;
			err <= 1'b0;
		end else begin
			toEx.valid <= instrValid && !stall && !redirect && !illegal;
			// Sticky until the next reset
			if (instrValid && !redirect && illegal) begin
				err <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		toEx.op <= op;
		toEx.dest <= rd;
		toEx.writesReg <= writes;
		toEx.aVal <= aVal;
		toEx.bVal <= bVal;
		toEx.imm <= immExt;
		toEx.pc <= instrPc;
	end

endmodule

`default_nettype wire

// File: design/executeStage.sv
// ALU and branch resolution. Load and store addresses land in the data half
`timescale 1ns/100ps
`default_nettype none

module executeStage (
	input logic clk,
	input logic rst,
	decExLink.consumer fromDec,
	exMemLink.producer toMem,
	output logic redirect,
	output memPkg::memAddr_t redirectPc
);
	import isaPkg::*;
	import memPkg::*;

	word_t result;
	word_t addrSum;
	memAddr_t effAddr;

	assign addrSum = fromDec.aVal + fromDec.imm;
	// Top address bit forced, so data never overlaps code
	assign effAddr = memAddr_t'(addrSum) | {1'b1, {($bits(memAddr_t)-1){1'b0}}};

	always_comb begin
		case (fromDec.op)
			opAdd: result = fromDec.aVal + fromDec.bVal;
			opSub: result = fromDec.aVal - fromDec.bVal;
			opAnd: result = fromDec.aVal & fromDec.bVal;
			opXor: result = fromDec.aVal ^ fromDec.bVal;
			opAddi: result = addrSum;
			opLoad, opStore: result = word_t'(effAddr);
			default: result = '0;
		endcase
	end

	// Taken beqz redirects for this one cycle
	assign redirect = fromDec.valid && (fromDec.op == opBeqz) && (fromDec.aVal == '0);
	assign redirectPc = fromDec.pc + memAddr_t'(1) + memAddr_t'(fromDec.imm);

	always_ff @(posedge clk) begin
		if (rst) begin
			toMem.valid <= 1'b0;
		end else begin
			toMem.valid <= fromDec.valid;
		end
	end

	always_ff @(posedge clk) begin
		toMem.op <= fromDec.op;
		toMem.dest <= fromDec.dest;
		toMem.writesReg <= fromDec.writesReg;
		toMem.result <= result;
		toMem.storeData <= fromDec.bVal;
	end

endmodule

`default_nettype wire

// File: design/memoryStage.sv
// Data access and writeback. The data port always wins arbitration
// Nothing retires or touches memory once halted is set
`timescale 1ns/100ps
`default_nettype none

module memoryStage (
	input logic clk,
	input logic rst,
	exMemLink.consumer fromEx,
	memBus.requester bus,
	output logic wbEn,
	output isaPkg::regIdx_t wbReg,
	output isaPkg::word_t wbData,
	output logic halted
);
	import isaPkg::*;
	import memPkg::*;

	logic active;
	logic isLoad;
	logic isStore;

	assign active = fromEx.valid && !halted;
	assign isLoad = (fromEx.op == opLoad);
	assign isStore = (fromEx.op == opStore);

	assign bus.req = active && (isLoad || isStore);
	assign bus.write = isStore;
	assign bus.addr = memAddr_t'(fromEx.result);
	assign bus.wdata = fromEx.storeData;

	// Also the retire trace, r0 writes are dropped
	assign wbEn = active && fromEx.writesReg && (fromEx.dest != '0);
	assign wbReg = fromEx.dest;
	assign wbData = (isLoad && bus.grant) ? bus.rdata : fromEx.result;

	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
		end else if (fromEx.valid && fromEx.op == opHalt) begin
			halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/cpuCore.sv
// Four-stage core top. Words decoded past a halt still raise err if illegal,
// so fill the unused code region with nop during load
`timescale 1ns/100ps
`default_nettype none

module cpuCore (
	input logic clk,
	input logic rst,
	input logic loadEn,
	input memPkg::memAddr_t loadAddr,
	input isaPkg::word_t loadData,
	output logic retireValid,
	output isaPkg::regIdx_t retireReg,
	output isaPkg::word_t retireData,
	output logic halted,
	output logic err
);
	import isaPkg::*;
	import memPkg::*;

	memBus fetchBus ();
	memBus dataBus ();
	decExLink decEx ();
	exMemLink exMem ();

	logic stall;
	logic redirect;
	memAddr_t redirectPc;
	word_t instr;
	memAddr_t instrPc;
	logic instrValid;

	sharedMemory sharedMemory_i (
		.clk(clk),
		.rst(rst),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.fetchBus(fetchBus.arbiter),
		.dataBus(dataBus.arbiter)
	);

	fetchStage fetchStage_i (
		.clk(clk),
		.rst(rst),
		.bus(fetchBus.requester),
		.stall(stall),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.halted(halted),
		.instr(instr),
		.instrPc(instrPc),
		.instrValid(instrValid)
	);

	// Writeback port doubles as the retire trace
	decodeStage decodeStage_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrPc(instrPc),
		.instrValid(instrValid),
		.redirect(redirect),
		.wbEn(retireValid),
		.wbReg(retireReg),
		.wbData(retireData),
		.stall(stall),
		.err(err),
		.toEx(decEx.producer),
		.exMon(exMem.monitor)
	);

	executeStage executeStage_i (
		.clk(clk),
		.rst(rst),
		.fromDec(decEx.consumer),
		.toMem(exMem.producer),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	memoryStage memoryStage_i (
		.clk(clk),
		.rst(rst),
		.fromEx(exMem.consumer),
		.bus(dataBus.requester),
		.wbEn(retireValid),
		.wbReg(retireReg),
		.wbData(retireData),
		.halted(halted)
	);

endmodule

`default_nettype wire

// File: testbench/cpuTb.sv
// Seeded random program checked against an ISA model, then a directed illegal-opcode run
// Loading needs rst high, so reset spans the whole memory load plus 16 quiet cycles
`timescale 1ns/100ps
`default_nettype none

`include "cpuSettings.svh"

module cpuTb;
	import isaPkg::*;
	import memPkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int PROG_LEN = 100;
	localparam int HALT_TIMEOUT = 5000;
	localparam int MODEL_STEP_LIMIT = 1000;
	localparam int SETTLE_CYCLES = 10;
	localparam int PC_BITS = $clog2(`CPU_CODE_WORDS);

	logic clk;
	logic rst;
	logic loadEn;
	memAddr_t loadAddr;
	word_t loadData;
	logic retireValid;
	regIdx_t retireReg;
	word_t retireData;
	logic halted;
	logic err;

	word_t image [`CPU_MEM_WORDS];
	regIdx_t expReg [$];
	word_t expData [$];
	logic expErr;
	logic tracing;
	int retireCount;
	int modelCount;
	int valueErrors;
	int otherErrors;

	cpuCore cpuCore_i (
		.clk(clk),
		.rst(rst),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.retireValid(retireValid),
		.retireReg(retireReg),
		.retireData(retireData),
		.halted(halted),
		.err(err)
	);

	always #10 clk = ~clk;

	task automatic checkReg(string sig, regIdx_t got, regIdx_t exp);
		if (got !== exp) begin
			valueErrors++;
			$display("Fail at %0t ns: %s is r%0d, expected r%0d", $time, sig, got, exp);
		end
	endtask

	task automatic checkWord(string sig, word_t got, word_t exp);
		if (got !== exp) begin
			valueErrors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
		end
	endtask

	task automatic checkFlag(string sig, logic got, logic exp);
		if (got !== exp) begin
			valueErrors++;
			$display("Fail at %0t ns: %s is %b, expected %b", $time, sig, got, exp);
		end
	endtask

	task automatic checkCount(string sig, int got, int exp);
		if (got != exp) begin
			valueErrors++;
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, sig, got, exp);
		end
	endtask

	function automatic word_t encode(opcode_t op, int rd, int rs, int low6);
		encode = {op, 3'(rd), 3'(rs), 6'(low6)};
	endfunction

	task automatic setCode(int at, word_t w);
		image[memAddr_t'(at)] = w;
	endtask

	// Code region gets nop and data words get a pattern built from the whole address
	task automatic fillImage();
		int a;
		for (a = 0; a < `CPU_MEM_WORDS; a++) begin
			if (a < `CPU_CODE_WORDS) begin
				setCode(a, encode(opNop, 0, 0, 0));
			end else begin
				setCode(a, {8'(a), 8'(a) ^ 8'hA5});
			end
		end
	endtask

	task automatic buildRandomProgram();
		int i;
		int kind;
		int rs;
		int imm;
		int maxOff;
		int lastRd;
		fillImage();
		// Defined start values for r1 to r7
		for (i = 1; i < `CPU_REG_COUNT; i++) begin
			setCode(i - 1, encode(opAddi, i, 0, int'($urandom)));
		end
		lastRd = `CPU_REG_COUNT - 1;
		i = `CPU_REG_COUNT - 1;
		while (i < PROG_LEN) begin
			kind = int'($urandom % 10);
			// Half the sources reuse the last destination to force interlocks
			rs = ($urandom % 2 == 0) ? lastRd : int'($urandom % 8);
			imm = int'($urandom);
			if (kind < 4) begin
				lastRd = int'($urandom % 8);
				setCode(i, encode(opcode_t'(4'($urandom % 4)), lastRd, rs,
					int'($urandom % 8) << 3));
			end else if (kind < 6) begin
				lastRd = int'($urandom % 8);
				setCode(i, encode(opAddi, lastRd, rs, imm));
			end else if (kind < 8 && i < PROG_LEN - 1) begin
				// Store then load through the same base and offset
				setCode(i, encode(opStore, int'($urandom % 8), rs, imm));
				i++;
				lastRd = int'($urandom % 8);
				setCode(i, encode(opLoad, lastRd, rs, imm));
			end else if (kind < 9) begin
				// Forward only and never past the final halt
				maxOff = (PROG_LEN - 1 - i < 31) ? PROG_LEN - 1 - i : 31;
				setCode(i, encode(opBeqz, 0, int'($urandom % 4),
					int'($urandom % (maxOff + 1))));
			end else begin
				setCode(i, encode(opNop, 0, 0, 0));
			end
			i++;
		end
		setCode(PROG_LEN, encode(opHalt, 0, 0, 0));
	endtask

	task automatic buildIllegalProgram();
		fillImage();
		setCode(0, encode(opAddi, 1, 0, 5));
		// Opcode 4'hA lies outside the instruction set
		setCode(1, 16'hA000);
		setCode(2, encode(opAddi, 2, 1, 3));
		setCode(3, encode(opStore, 2, 0, 1));
		setCode(4, encode(opLoad, 3, 0, 1));
		setCode(5, encode(opHalt, 0, 0, 0));
	endtask

	// Sequential ISA model that runs one instruction per step
	task automatic runModel();
		word_t mem [`CPU_MEM_WORDS];
		word_t regs [`CPU_REG_COUNT];
		logic [PC_BITS-1:0] pc;
		opcode_t op;
		word_t ir;
		word_t a;
		word_t b;
		word_t imm;
		word_t res;
		memAddr_t addr;
		logic done;
		int steps;
		int r;
		mem = image;
		for (r = 0; r < `CPU_REG_COUNT; r++) begin
			regs[regIdx_t'(r)] = '0;
		end
		expReg.delete();
		expData.delete();
		expErr = 1'b0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < MODEL_STEP_LIMIT) begin
			ir = mem[memAddr_t'(pc)];
			op = opcode_t'(ir[15:12]);
			a = regs[ir[8:6]];
			b = (op == opStore) ? regs[ir[11:9]] : regs[ir[5:3]];
			imm = {{(`CPU_WORD_BITS-6){ir[5]}}, ir[5:0]};
			// Data always lands in the upper half
			addr = memAddr_t'(a + imm) | 8'h80;
			res = '0;
			pc = pc + 1'b1;
			steps++;
			case (op)
				opAdd: res = a + b;
				opSub: res = a - b;
				opAnd: res = a & b;
				opXor: res = a ^ b;
				opAddi: res = a + imm;
				opLoad: res = mem[addr];
				opStore: mem[addr] = b;
				opBeqz: begin
					if (a == '0) begin
						pc = pc + imm[PC_BITS-1:0];
					end
				end
				opHalt: done = 1'b1;
				opNop: begin
				end
				default: expErr = 1'b1;
			endcase
			if ((op inside {opAdd, opSub, opAnd, opXor, opAddi, opLoad}) && ir[11:9] != '0) begin
				regs[ir[11:9]] = res;
				expReg.push_back(ir[11:9]);
				expData.push_back(res);
			end
		end
		if (!done) begin
			otherErrors++;
			$display("Model did not reach a halt within %0d steps", MODEL_STEP_LIMIT);
		end
		modelCount = expReg.size();
	endtask

	task automatic waitDriveSlot();
		@(posedge clk);
		#2;
	endtask

	task automatic loadAndReset();
		int a;
		waitDriveSlot();
		rst = 1'b1;
		for (a = 0; a < `CPU_MEM_WORDS; a++) begin
			loadEn = 1'b1;
			loadAddr = memAddr_t'(a);
			loadData = image[memAddr_t'(a)];
			waitDriveSlot();
		end
		loadEn = 1'b0;
		repeat (RESET_CYCLES) waitDriveSlot();
		rst = 1'b0;
	endtask

	// err must not fall again once seen
	task automatic stepAndWatchErr(inout logic errSeen);
		@(negedge clk);
		if (errSeen) begin
			checkFlag("err", err, 1'b1);
		end
		errSeen = errSeen | err;
	endtask

	task automatic runProgram(string name);
		int cycles;
		logic errSeen;
		runModel();
		retireCount = 0;
		errSeen = 1'b0;
		loadAndReset();
		tracing = 1'b1;
		@(negedge clk);
		checkFlag("retireValid", retireValid, 1'b0);
		checkFlag("halted", halted, 1'b0);
		checkFlag("err", err, 1'b0);
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			stepAndWatchErr(errSeen);
			cycles++;
		end
		if (!halted) begin
			otherErrors++;
			$display("Timeout in %s run: halted still low after %0d cycles", name, HALT_TIMEOUT);
		end
		// Extra retires here show up in the trace monitor
		for (cycles = 0; cycles < SETTLE_CYCLES; cycles++) begin
			stepAndWatchErr(errSeen);
		end
		tracing = 1'b0;
		checkFlag("halted", halted, 1'b1);
		checkFlag("err", err, expErr);
		checkCount("retire count", retireCount, modelCount);
	endtask

	always @(negedge clk) begin
		if (tracing && retireValid) begin
			retireCount++;
			if (expReg.size() == 0) begin
				otherErrors++;
				$display("Unexpected retire of r%0d at %0t ns after the model's trace ran out",
					retireReg, $time);
			end else begin
				checkReg("retireReg", retireReg, expReg.pop_front());
				checkWord("retireData", retireData, expData.pop_front());
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		tracing = 1'b0;
		retireCount = 0;
		modelCount = 0;
		valueErrors = 0;
		otherErrors = 0;
		void'($urandom(32'h7355_cbe3));
		buildRandomProgram();
		runProgram("random");
		buildIllegalProgram();
		runProgram("illegal opcode");
		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/isaPkg.sv
design/memPkg.sv
design/cpuLinks.sv
design/sharedMemory.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuCore.sv
testbench/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator and run; exit status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module cpuTb -o cpuTbSim &&
./obj_dir/cpuTbSim | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null &&
echo "Simulation run OK" || { echo "Simulation run failed"; exit 1; }
